// File: hw/mips_pkg.sv
package mips_pkg;

	// Reset vector of the MIPS boot ROM
	localparam logic [31:0] boot_addr = 32'hBFC0_0000;

	// Primary opcodes, bits 31:26
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_slti    = 6'h0A;
	localparam logic [5:0] op_sltiu   = 6'h0B;
	localparam logic [5:0] op_andi    = 6'h0C;
	localparam logic [5:0] op_ori     = 6'h0D;
	localparam logic [5:0] op_xori    = 6'h0E;
	localparam logic [5:0] op_lui     = 6'h0F;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2B;

	// Function codes under op_special, bits 5:0
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2A;
	localparam logic [5:0] fn_sltu = 6'h2B;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_lui
	} alu_op_e;

	// R-type layout, immediate and jump index overlap the low bits
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    dst_rd;
		logic    alu_src_imm;
		logic    imm_zero_ext;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
		alu_op_e alu_op;
	} ctrl_t;

endpackage

// File: hw/mips_decoder.sv
`timescale 1ns/1ns

module mips_decoder (
	input  mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t  ctrl
);

	always_comb begin
		// Default bundle is a no-op
		ctrl = '0;
		ctrl.alu_op = mips_pkg::alu_add;

		case (instr.opcode)
			mips_pkg::op_special: begin
				// R-type writes rd from two registers
				ctrl.reg_write = 1'b1;
				ctrl.dst_rd = 1'b1;
				case (instr.funct)
					mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
					mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
					mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
					mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
					mips_pkg::fn_jr: begin
						// Jump through rs, nothing written back
						ctrl.reg_write = 1'b0;
						ctrl.jump_reg = 1'b1;
					end
					default: begin
						// Unknown funct acts as a no-op
						ctrl.reg_write = 1'b0;
						ctrl.dst_rd = 1'b0;
					end
				endcase
			end
			mips_pkg::op_j: ctrl.jump = 1'b1;
			mips_pkg::op_beq: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op = mips_pkg::alu_sub;
			end
			mips_pkg::op_bne: begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op = mips_pkg::alu_sub;
			end
			mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
			mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori,
			mips_pkg::op_lui: begin
				// Immediate ops write rt
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				case (instr.opcode)
					mips_pkg::op_slti:  ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::op_sltiu: ctrl.alu_op = mips_pkg::alu_sltu;
					mips_pkg::op_lui:   ctrl.alu_op = mips_pkg::alu_lui;
					mips_pkg::op_andi: begin
						ctrl.alu_op = mips_pkg::alu_and;
						ctrl.imm_zero_ext = 1'b1;
					end
					mips_pkg::op_ori: begin
						ctrl.alu_op = mips_pkg::alu_or;
						ctrl.imm_zero_ext = 1'b1;
					end
					mips_pkg::op_xori: begin
						ctrl.alu_op = mips_pkg::alu_xor;
						ctrl.imm_zero_ext = 1'b1;
					end
					default: ctrl.alu_op = mips_pkg::alu_add;
				endcase
			end
			mips_pkg::op_lw: begin
				// Address is rs plus signed offset
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			mips_pkg::op_sw: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// File: hw/mips_regfile.sv
`timescale 1ns/1ns

module mips_regfile (
	input  logic        clk,
	input  logic        reset,
	input  logic        write_en,
	input  logic [4:0]  read_addr_a,
	input  logic [4:0]  read_addr_b,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	output logic [31:0] register_v0
);

	logic [31:0] regs [32];

	// Cleared on reset, $zero never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != 5'd0) begin
			regs[write_addr] <= write_data;
		end
	end

	// Combinational reads, $zero forced
	always_comb begin
		read_data_a = (read_addr_a == 5'd0) ? 32'd0 : regs[read_addr_a];
		read_data_b = (read_addr_b == 5'd0) ? 32'd0 : regs[read_addr_b];
	end

	// v0 is register 2
	assign register_v0 = regs[2];

endmodule

// File: hw/mips_alu.sv
`timescale 1ns/1ns

module mips_alu (
	input  mips_pkg::alu_op_e op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [4:0]        shamt,
	output logic [31:0]       result,
	output logic              zero
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        lt_signed;
	logic        lt_unsigned;

	assign sum = a + b;
	assign diff = a - b;

	// Sign bits differ: a negative means less
	assign lt_signed = (a[31] != b[31]) ? a[31] : diff[31];
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			mips_pkg::alu_add:  result = sum;
			mips_pkg::alu_sub:  result = diff;
			mips_pkg::alu_and:  result = a & b;
			mips_pkg::alu_or:   result = a | b;
			mips_pkg::alu_xor:  result = a ^ b;
			mips_pkg::alu_slt:  result = {31'd0, lt_signed};
			mips_pkg::alu_sltu: result = {31'd0, lt_unsigned};
			// Shifts act on rt, amount from the instruction
			mips_pkg::alu_sll:  result = b << shamt;
			mips_pkg::alu_srl:  result = b >> shamt;
			// Immediate goes to the upper half
			mips_pkg::alu_lui:  result = {b[15:0], 16'd0};
			default:            result = sum;
		endcase
	end

	// Equality for BEQ and BNE
	assign zero = (a == b);

endmodule

// File: hw/mips_next_pc.sv
`timescale 1ns/1ns

module mips_next_pc (
	input  logic            clk,
	input  logic            reset,
	input  logic            step,
	input  mips_pkg::ctrl_t ctrl,
	input  logic [31:0]     imm_ext,
	input  logic [25:0]     jump_index,
	input  logic [31:0]     rs_data,
	input  logic            equal,
	output logic [31:0]     pc,
	output logic            halting
);

	logic [31:0] pc_plus4;
	logic [31:0] target;
	logic        taken;

	assign pc_plus4 = pc + 32'd4;

	// No delay slot, branch offset from pc+4
	assign taken = (ctrl.branch_eq && equal) || (ctrl.branch_ne && !equal);

	always_comb begin
		if (ctrl.jump_reg) begin
			target = rs_data;
		end else if (ctrl.jump) begin
			target = {pc_plus4[31:28], jump_index, 2'b00};
		end else if (taken) begin
			target = pc_plus4 + {imm_ext[29:0], 2'b00};
		end else begin
			target = pc_plus4;
		end
	end

	// Jump to address zero ends the program
	assign halting = (target == 32'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= mips_pkg::boot_addr;
		end else if (step) begin
			pc <= target;
		end
	end

endmodule

// File: hw/mips_cpu_harvard.sv
`timescale 1ns/1ns

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	output logic        active,
	output logic [31:0] register_v0,
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);

	mips_pkg::instr_t instr;
	mips_pkg::ctrl_t  ctrl;
	logic             step;
	logic             halting;
	logic             equal;
	logic [31:0]      imm_ext;
	logic [31:0]      rs_data;
	logic [31:0]      rt_data;
	logic [31:0]      alu_b;
	logic [31:0]      alu_result;
	logic [31:0]      write_back;
	logic [4:0]       write_addr;

	assign instr = mips_pkg::instr_t'(instr_readdata);

	// One instruction retires per enabled edge
	assign step = clk_enable && active;

	mips_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	// Immediate is the low half of the word
	assign imm_ext = ctrl.imm_zero_ext ? {16'd0, instr_readdata[15:0]}
		: {{16{instr_readdata[15]}}, instr_readdata[15:0]};

	assign write_addr = ctrl.dst_rd ? instr.rd : instr.rt;

	// Load data or ALU result back to the register file
	assign write_back = ctrl.mem_to_reg ? data_readdata : alu_result;

	mips_regfile u_regfile (
		.clk         (clk),
		.reset       (reset),
		.write_en    (step && ctrl.reg_write),
		.read_addr_a (instr.rs),
		.read_addr_b (instr.rt),
		.write_addr  (write_addr),
		.write_data  (write_back),
		.read_data_a (rs_data),
		.read_data_b (rt_data),
		.register_v0 (register_v0)
	);

	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_data;

	mips_alu u_alu (
		.op     (ctrl.alu_op),
		.a      (rs_data),
		.b      (alu_b),
		.shamt  (instr.shamt),
		.result (alu_result),
		.zero   (equal)
	);

	mips_next_pc u_next_pc (
		.clk        (clk),
		.reset      (reset),
		.step       (step),
		.ctrl       (ctrl),
		.imm_ext    (imm_ext),
		.jump_index (instr_readdata[25:0]),
		.rs_data    (rs_data),
		.equal      (equal),
		.pc         (instr_address),
		.halting    (halting)
	);

	// Data bus strobes only while stepping
	assign data_address = alu_result;
	assign data_writedata = rt_data;
	assign data_write = step && ctrl.mem_write;
	assign data_read = step && ctrl.mem_read;

	// Drops on the edge that loads PC zero
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b1;
		end else if (step && halting) begin
			active <= 1'b0;
		end
	end

endmodule

// File: test/mips_cpu_asserts.sv
`timescale 1ns/1ns

module mips_cpu_asserts (
	input logic        clk,
	input logic        reset,
	input logic        clk_enable,
	input logic        active,
	input logic        data_write,
	input logic        data_read,
	input logic [31:0] instr_address
);

	// Count of failed properties
	int unsigned errors = 0;

	// LW and SW never in the same cycle
	assert property (@(posedge clk) disable iff (reset) !(data_read && data_write))
		else begin
			errors++;
			$error("data_read and data_write high together");
		end

	// Halted core stores nothing
	assert property (@(posedge clk) disable iff (reset) !active |-> !data_write)
		else begin
			errors++;
			$error("data_write high while the core is halted");
		end

	// Stall freezes the PC
	assert property (@(posedge clk) disable iff (reset) !clk_enable |=> $stable(instr_address))
		else begin
			errors++;
			$error("instr_address moved while clk_enable was low");
		end

	assert property (@(posedge clk) disable iff (reset) active |-> instr_address[1:0] == 2'b00)
		else begin
			errors++;
			$error("instr_address not word aligned");
		end

endmodule

bind mips_cpu_harvard mips_cpu_asserts u_asserts (.*);

// File: test/mips_cpu_tb.sv
`timescale 1ns/1ns

module mips_cpu_tb;

	typedef enum logic [4:0] {
		k_addu, k_subu, k_and, k_or, k_xor, k_slt, k_sltu, k_sll, k_srl,
		k_addiu, k_andi, k_ori, k_xori, k_slti, k_lui, k_mem, k_beq, k_bne, k_stall
	} kind_e;

	// One test program: what runs, and its operands
	typedef struct packed {
		kind_e       kind;
		logic        rnd;
		logic [31:0] a;
		logic [31:0] b;
	} case_t;

	localparam int n_cases = 22;
	localparam int cycle_limit = n_cases * 32;
	localparam logic [4:0] r_v0 = 5'd2;
	localparam logic [4:0] r_t0 = 5'd8;
	localparam logic [4:0] r_t1 = 5'd9;
	// SW $zero, 0($zero)
	localparam logic [31:0] park_instr = {mips_pkg::op_sw, 5'd0, 5'd0, 16'h0000};

	case_t cases [n_cases] = '{
		'{k_addu, 1'b1, 32'h0, 32'h0}, '{k_subu, 1'b1, 32'h0, 32'h0},
		'{k_and, 1'b1, 32'h0, 32'h0}, '{k_or, 1'b1, 32'h0, 32'h0},
		'{k_xor, 1'b1, 32'h0, 32'h0}, '{k_slt, 1'b1, 32'h0, 32'h0},
		'{k_slt, 1'b0, 32'hFFFF_FFFB, 32'h3}, '{k_sltu, 1'b1, 32'h0, 32'h0},
		'{k_sll, 1'b1, 32'h0, 32'h0}, '{k_srl, 1'b1, 32'h0, 32'h0},
		'{k_addiu, 1'b1, 32'h0, 32'h0}, '{k_andi, 1'b1, 32'h0, 32'h0},
		'{k_ori, 1'b1, 32'h0, 32'h0}, '{k_xori, 1'b1, 32'h0, 32'h0},
		'{k_slti, 1'b1, 32'h0, 32'h0}, '{k_lui, 1'b1, 32'h0, 32'h0},
		'{k_mem, 1'b1, 32'h0, 32'h0}, '{k_beq, 1'b0, 32'h5, 32'h5},
		'{k_beq, 1'b0, 32'h5, 32'h6}, '{k_bne, 1'b0, 32'h5, 32'h5},
		'{k_bne, 1'b0, 32'h5, 32'h6}, '{k_stall, 1'b1, 32'h0, 32'h0}
	};

	logic        clk = 1'b0;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;
	logic [31:0] rom [16];
	logic [31:0] dmem [64];
	logic [31:0] rom_offset;
	logic [15:0] lfsr_state;
	int          cycles = 0;

	mips_cpu_harvard u_dut (.*);

	always #4 clk = ~clk;

	// ROM sits at the boot address
	// Outside it every word is a store, so a halted core that ran on would write
	assign rom_offset = instr_address - mips_pkg::boot_addr;
	assign instr_readdata = (rom_offset < 32'd64) ? rom[rom_offset[5:2]] : park_instr;

	// Data RAM, 64 words, read data only during a load
	assign data_readdata = data_read ? dmem[data_address[7:2]] : 32'hx;
	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_address[7:2]] <= data_writedata;
		end
	end

	task automatic fail_run(string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			fail_run("Timeout, the programs did not halt within the cycle limit");
		end
	end

	// Bound bus checker on the DUT
	always @(negedge clk) begin
		if (u_dut.u_asserts.errors != 0) begin
			fail_run("A bus rule assertion on the DUT failed");
		end
	end

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			fail_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// x16 + x14 + x13 + x11, one step per bit
	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			w = {w[30:0], lfsr_state[0]};
		end
		return w;
	endfunction

	function automatic logic [31:0] rtype(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [4:0] shamt, logic [5:0] funct);
		return {mips_pkg::op_special, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Instruction under test, result into v0
	function automatic logic [31:0] test_instr(kind_e k, logic [31:0] a, logic [31:0] b);
		case (k)
			k_subu:  return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_subu);
			k_and:   return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_and);
			k_or:    return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_or);
			k_xor:   return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_xor);
			k_slt:   return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_slt);
			k_sltu:  return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_sltu);
			k_sll:   return rtype(5'd0, r_t1, r_v0, a[4:0], mips_pkg::fn_sll);
			k_srl:   return rtype(5'd0, r_t1, r_v0, a[4:0], mips_pkg::fn_srl);
			k_addiu: return itype(mips_pkg::op_addiu, r_t0, r_v0, b[15:0]);
			k_andi:  return itype(mips_pkg::op_andi, r_t0, r_v0, b[15:0]);
			k_ori:   return itype(mips_pkg::op_ori, r_t0, r_v0, b[15:0]);
			k_xori:  return itype(mips_pkg::op_xori, r_t0, r_v0, b[15:0]);
			k_slti:  return itype(mips_pkg::op_slti, r_t0, r_v0, b[15:0]);
			k_lui:   return itype(mips_pkg::op_lui, 5'd0, r_v0, b[15:0]);
			default: return rtype(r_t0, r_t1, r_v0, 5'd0, mips_pkg::fn_addu);
		endcase
	endfunction

	// Reference model, immediate is the low half of b
	function automatic logic [31:0] ref_result(kind_e k, logic [31:0] a, logic [31:0] b);
		logic [31:0] sext;
		logic [31:0] zext;
		sext = {{16{b[15]}}, b[15:0]};
		zext = {16'h0, b[15:0]};
		case (k)
			k_subu:  return a - b;
			k_and:   return a & b;
			k_or:    return a | b;
			k_xor:   return a ^ b;
			k_slt:   return {31'd0, $signed(a) < $signed(b)};
			k_sltu:  return {31'd0, a < b};
			k_sll:   return b << a[4:0];
			k_srl:   return b >> a[4:0];
			k_addiu: return a + sext;
			k_andi:  return a & zext;
			k_ori:   return a | zext;
			k_xori:  return a ^ zext;
			k_slti:  return {31'd0, $signed(a) < $signed(sext)};
			k_lui:   return {b[15:0], 16'h0};
			k_mem:   return b;
			// Taken branch skips the add of 2
			k_beq:   return (a == b) ? 32'd1 : 32'd3;
			k_bne:   return (a != b) ? 32'd1 : 32'd3;
			default: return a + b;
		endcase
	endfunction

	task automatic load_program(kind_e k, logic [31:0] a, logic [31:0] b);
		logic [31:0] prog [$];
		// Operands into t0 and t1
		prog = {itype(mips_pkg::op_lui, 5'd0, r_t0, a[31:16]),
			itype(mips_pkg::op_ori, r_t0, r_t0, a[15:0]),
			itype(mips_pkg::op_lui, 5'd0, r_t1, b[31:16]),
			itype(mips_pkg::op_ori, r_t1, r_t1, b[15:0])};
		case (k)
			k_mem: begin
				prog.push_back(itype(mips_pkg::op_sw, 5'd0, r_t1, 16'h0040));
				prog.push_back(itype(mips_pkg::op_lw, 5'd0, r_v0, 16'h0040));
			end
			k_beq, k_bne: begin
				prog.push_back(itype(mips_pkg::op_addiu, 5'd0, r_v0, 16'd1));
				prog.push_back(itype((k == k_beq) ? mips_pkg::op_beq : mips_pkg::op_bne,
					r_t0, r_t1, 16'd1));
				prog.push_back(itype(mips_pkg::op_addiu, r_v0, r_v0, 16'd2));
			end
			default: prog.push_back(test_instr(k, a, b));
		endcase
		// JR $zero halts
		prog.push_back(rtype(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
		for (int i = 0; i < 16; i++) begin
			rom[i] = (i < prog.size()) ? prog[i] : 32'h0;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = ~(32'(i) << 2);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		clk_enable = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		check_value("instr_address", instr_address, mips_pkg::boot_addr);
		check_value("active", active, 32'd1);
		check_value("register_v0", register_v0, 32'd0);
	endtask

	// Freeze mid-program, nothing may move
	task automatic hold_stalled(int n);
		logic [31:0] pc_held;
		logic [31:0] v0_held;
		clk_enable = 1'b0;
		pc_held = instr_address;
		v0_held = register_v0;
		repeat (n) begin
			@(negedge clk);
			check_value("instr_address", instr_address, pc_held);
			check_value("register_v0", register_v0, v0_held);
		end
		clk_enable = 1'b1;
	endtask

	// Core must stay parked at zero
	task automatic check_halted();
		repeat (3) begin
			check_value("active", active, 32'd0);
			check_value("instr_address", instr_address, 32'd0);
			check_value("data_write", data_write, 32'd0);
			@(negedge clk);
		end
	endtask

	initial begin
		case_t       c;
		logic [31:0] a;
		logic [31:0] b;
		int          steps;
		reset = 1'b1;
		clk_enable = 1'b0;
		lfsr_state = 16'd64158;
		for (int n = 0; n < n_cases; n++) begin
			c = cases[n];
			a = c.a;
			b = c.b;
			if (c.rnd) begin
				a = rand_word();
				b = rand_word();
			end
			load_program(c.kind, a, b);
			apply_reset();
			clk_enable = 1'b1;
			steps = 0;
			while (active) begin
				@(negedge clk);
				steps++;
				// After four edges the operands are loaded, the op is next
				if (c.kind == k_stall && steps == 4) begin
					hold_stalled(4);
				end
			end
			check_halted();
			check_value("register_v0", register_v0, ref_result(c.kind, a, b));
			if (c.kind == k_mem) begin
				check_value("dmem[0x40]", dmem[16], b);
			end
		end
		if (u_dut.u_asserts.errors != 0) begin
			fail_run("A bus rule assertion on the DUT failed");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: vlog.f
hw/mips_pkg.sv
hw/mips_decoder.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_next_pc.sv
hw/mips_cpu_harvard.sv
test/mips_cpu_asserts.sv
test/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - hw/mips_pkg.sv
  - hw/mips_decoder.sv
  - hw/mips_regfile.sv
  - hw/mips_alu.sv
  - hw/mips_next_pc.sv
  - hw/mips_cpu_harvard.sv
  - target: test
    files:
      - test/mips_cpu_asserts.sv
      - test/mips_cpu_tb.sv
